//--- verilog.f
+incdir+tests
common/polyPkg.sv
lineDraw/lineDraw.sv
polygon/polygonSeq.sv
rtl/pixelClip.sv
rtl/quadRenderer.sv
tests/tbQuadRenderer.sv

//--- run.sh
#!/bin/sh
# build the quad renderer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tbQuadRenderer \
    -o simQuadRenderer
status=$?
if [ $status -ne 0 ]; then
    echo "run.sh: verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simQuadRenderer 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "run.sh: pass line not found in simulation output"
exit 1

//--- tests/lineModel.svh
`ifndef LINE_MODEL_SVH
`define LINE_MODEL_SVH

// ========================================================================
// reference model of the pixel stream
// ========================================================================
localparam int MaxLinePoints = 4096;            // far beyond any table line

pixelT expectQ[$];                              // expected pixels, oldest first

// visible area on plain integers
function automatic bit inScreen(input int x, input int y);
    return (x >= 0) && (x < ScreenWidth) && (y >= 0) && (y < ScreenHeight);
endfunction

// one drawn point, kept only when visible
task automatic addPoint(input int x, input int y, input colorT c);
    pixelT p;
    if (inScreen(x, y)) begin
        p.x     = ScreenXWidth'(x);
        p.y     = ScreenYWidth'(y);
        p.color = c;
        expectQ.push_back(p);
    end
endtask

// all-octant bresenham walk, both endpoints included
task automatic expandLine(input vertexT a, input vertexT b, input colorT c);
    int x;
    int y;
    int xEnd;
    int yEnd;
    int dx;
    int dy;
    int sx;
    int sy;
    int err;
    int e2;
    int n;
    bit reached;
    x    = int'(a.x);                           // sign extended
    y    = int'(a.y);
    xEnd = int'(b.x);
    yEnd = int'(b.y);
    dx   = (xEnd > x) ? xEnd - x : x - xEnd;
    dy   = (yEnd > y) ? y - yEnd : yEnd - y;    // negated magnitude
    sx   = (x < xEnd) ? 1 : -1;
    sy   = (y < yEnd) ? 1 : -1;
    err  = dx + dy;
    reached = 1'b0;
    for (n = 0; (n < MaxLinePoints) && !reached; n++) begin
        addPoint(x, y, c);
        if ((x == xEnd) && (y == yEnd)) begin
            reached = 1'b1;
        end else begin
            e2 = 2 * err;
            if (e2 >= dy) begin                 // step along x
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin                 // step along y
                err += dx;
                y   += sy;
            end
        end
    end
endtask

// four edges in drawing order, corners show up twice
task automatic expandQuad(input quadT q, input colorT c);
    expectQ.delete();
    expandLine(q.v0, q.v1, c);
    expandLine(q.v1, q.v2, c);
    expandLine(q.v2, q.v3, c);
    expandLine(q.v3, q.v0, c);                  // closing edge
endtask

`endif

//--- tests/tbQuadRenderer.sv
`timescale 1ns/100ps
`default_nettype none

module tbQuadRenderer
    import polyPkg::*;
();

    localparam int NumEntries   = 8;
    localparam int ResetCycles  = 16;
    localparam int DriveDelay   = 5;            // ns after the rising edge
    localparam int FrameTimeout = 20000;        // cycles per frame
    localparam int DecoyCycle   = 3;            // ignored start goes here
    localparam logic [31:0] Seed = 32'd29589;

    // one table row, knownCount of -1 means model only
    typedef struct packed {
        quadT  quad;
        colorT color;
        int    knownCount;
    } stimT;

    logic  Clock;
    logic  rst;
    logic  start;
    quadT  quad;
    colorT color;
    logic  busy;
    logic  pixelValid;
    pixelT pixel;
    logic  frameDone;

    stimT        stimTable [NumEntries];
    logic [31:0] rngState;
    int          errorCount;

    `include "lineModel.svh"

    quadRenderer DUT (
        .Clock      (Clock),
        .rst        (rst),
        .start      (start),
        .quad       (quad),
        .color      (color),
        .busy       (busy),
        .pixelValid (pixelValid),
        .pixel      (pixel),
        .frameDone  (frameDone)
    );

    always #50 Clock = ~Clock;                  // 100 ns period

    // ========================================================================
    // failure paths and compare tasks
    // ========================================================================
    task automatic reportMismatch(input string msg);
        errorCount++;
        $display("CHECK FAILED @ %0t ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic stopRun(input string why);
        errorCount++;
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkPixel(input pixelT got, input pixelT exp, input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s: got (%0d,%0d) color %0d, expected (%0d,%0d) color %0d",
                what, got.x, got.y, got.color, exp.x, exp.y, exp.color));
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            reportMismatch($sformatf("%s: got %b, expected %b", what, got, exp));
        end
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp) begin
            reportMismatch($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    // ========================================================================
    // stimulus helpers
    // ========================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic quadT mkQuad(input int x0, input int y0, input int x1, input int y1,
                                    input int x2, input int y2, input int x3, input int y3);
        quadT q;
        q.v0.x = coordT'(x0);
        q.v0.y = coordT'(y0);
        q.v1.x = coordT'(x1);
        q.v1.y = coordT'(y1);
        q.v2.x = coordT'(x2);
        q.v2.y = coordT'(y2);
        q.v3.x = coordT'(x3);
        q.v3.y = coordT'(y3);
        return q;
    endfunction

    function automatic logic pixelOnScreen(input pixelT p);
        return (int'(p.x) < ScreenWidth) && (int'(p.y) < ScreenHeight);
    endfunction

    // hand counts are max(|dx|,|dy|)+1 per edge, summed
    task automatic fillTable();
        stimTable[0] = '{quad: mkQuad(10, 10, 200, 40, 210, 100, 20, 70),          // shallow
                         color: 3'd1, knownCount: 504};
        stimTable[1] = '{quad: mkQuad(300, 20, 320, 220, 310, 400, 290, 200),      // steep
                         color: 3'd2, knownCount: 764};
        stimTable[2] = '{quad: mkQuad(100, 100, 400, 100, 400, 300, 100, 300),     // axis aligned
                         color: 3'd3, knownCount: 1004};
        stimTable[3] = '{quad: mkQuad(50, 60, 50, 60, 50, 60, 50, 60),             // one point
                         color: 3'd4, knownCount: 4};
        stimTable[4] = '{quad: mkQuad(-30, -20, 60, 10, 40, 90, -50, 50),          // top left
                         color: 3'd5, knownCount: -1};
        stimTable[5] = '{quad: mkQuad(600, 440, 700, 460, 680, 520, 590, 500),     // bottom right
                         color: 3'd6, knownCount: -1};
        stimTable[6] = '{quad: mkQuad(-100, -100, -10, -100, -10, -10, -100, -10), // all hidden
                         color: 3'd7, knownCount: 0};
        stimTable[7] = '{quad: mkQuad(-200, 240, 320, -100, 900, 240, 320, 700),   // crosses all
                         color: 3'd0, knownCount: -1};
    endtask

    task automatic nextCycle();
        @(posedge Clock);
        #(DriveDelay);
    endtask

    task automatic driveStart(input stimT s);
        start = 1'b1;
        quad  = s.quad;
        color = s.color;
    endtask

    // start pulse with a random quad while a frame runs
    task automatic driveDecoy(input colorT frameColor);
        int c [8];
        int k;
        for (k = 0; k < 8; k++) begin
            rngState = xorshift32(rngState);
            c[k]     = int'(rngState % 32'd400);
        end
        start = 1'b1;
        quad  = mkQuad(c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7]);
        color = ~frameColor;                    // never the frame color
    endtask

    // ========================================================================
    // one frame, from the cycle after start to frameDone
    // ========================================================================
    task automatic runFrame(input int idx);
        stimT  entry;
        pixelT expPix;
        int    cycles;
        int    received;
        int    expCount;
        bit    finished;
        entry = stimTable[idx];
        expandQuad(entry.quad, entry.color);
        expCount = expectQ.size();
        if (entry.knownCount >= 0) begin
            checkCount(expCount, entry.knownCount, $sformatf("frame %0d model size", idx));
        end
        cycles   = 0;
        received = 0;
        finished = 1'b0;
        while (!finished) begin
            nextCycle();
            cycles++;
            if (cycles > FrameTimeout) begin
                stopRun($sformatf("frame %0d never signalled frameDone within %0d cycles",
                    idx, FrameTimeout));
            end
            if (cycles == 1) begin
                start = 1'b0;
                checkFlag(busy, 1'b1, $sformatf("frame %0d busy after start", idx));
                checkFlag(frameDone, 1'b0, $sformatf("frame %0d frameDone width", idx));
                checkFlag(pixelValid, 1'b0, $sformatf("frame %0d pixel after frameDone", idx));
            end else if (cycles == DecoyCycle) begin
                checkFlag(busy, 1'b1, $sformatf("frame %0d busy before decoy", idx));
                driveDecoy(entry.color);
            end else if (cycles == DecoyCycle + 1) begin
                start = 1'b0;
            end
            if (pixelValid) begin
                checkFlag(pixelOnScreen(pixel), 1'b1, $sformatf("frame %0d pixel in bounds", idx));
                if (expectQ.size() == 0) begin
                    stopRun($sformatf("frame %0d produced more pixels than expected", idx));
                end else begin
                    expPix = expectQ.pop_front();
                    checkPixel(pixel, expPix, $sformatf("frame %0d pixel %0d", idx, received));
                end
                received++;
            end
            if (frameDone) begin
                checkFlag(busy, 1'b0, $sformatf("frame %0d busy at frameDone", idx));
                checkFlag(pixelValid, 1'b0, $sformatf("frame %0d pixel at frameDone", idx));
                checkCount(received, expCount, $sformatf("frame %0d pixel count", idx));
                checkCount(expectQ.size(), 0, $sformatf("frame %0d leftover pixels", idx));
                if (idx + 1 < NumEntries) begin
                    driveStart(stimTable[idx + 1]);     // back to back start
                end
                finished = 1'b1;
            end
        end
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin : mainFlow
        int i;
        Clock      = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        quad       = '0;
        color      = '0;
        rngState   = Seed;
        errorCount = 0;
        fillTable();

        // outputs quiet through reset
        for (i = 0; i < ResetCycles; i++) begin
            nextCycle();
            checkFlag(busy, 1'b0, "busy in reset");
            checkFlag(pixelValid, 1'b0, "pixelValid in reset");
            checkFlag(frameDone, 1'b0, "frameDone in reset");
        end
        rst = 1'b0;

        // and idle before the first start
        for (i = 0; i < 4; i++) begin
            nextCycle();
            checkFlag(busy, 1'b0, "busy while idle");
            checkFlag(pixelValid, 1'b0, "pixelValid while idle");
            checkFlag(frameDone, 1'b0, "frameDone while idle");
        end

        driveStart(stimTable[0]);
        for (i = 0; i < NumEntries; i++) begin
            runFrame(i);
        end

        // tail after the last frame
        for (i = 0; i < 4; i++) begin
            nextCycle();
            checkFlag(busy, 1'b0, "busy after last frame");
            checkFlag(pixelValid, 1'b0, "pixelValid after last frame");
            checkFlag(frameDone, 1'b0, "frameDone after last frame");
        end

        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/quadRenderer.sv
`timescale 1ns/100ps
`default_nettype none

module quadRenderer
    import polyPkg::*;
(
    input  wire logic  Clock,
    input  wire logic  rst,
    input  wire logic  start,                   // taken only while busy is low
    input  wire quadT  quad,
    input  wire colorT color,
    output logic       busy,
    output logic       pixelValid,              // no back-pressure
    output pixelT      pixel,
    output logic       frameDone                // one cycle after the last pixel
);

    // sequencer to stepper
    logic   lineStart;
    lineT   lineEdge;
    logic   lineBusy;
    logic   lineDone;

    // stepper to clipper
    logic   pointValid;
    vertexT point;
    colorT  drawColor;

    // ========================================================================
    // edge sequencer
    // ========================================================================
    polygonSeq uSeq (
        .Clock     (Clock),
        .rst       (rst),
        .start     (start),
        .quad      (quad),
        .color     (color),
        .lineBusy  (lineBusy),
        .lineDone  (lineDone),
        .lineStart (lineStart),
        .lineEdge  (lineEdge),
        .drawColor (drawColor),
        .busy      (busy),
        .frameDone (frameDone)
    );

    // bresenham stepper
    lineDraw uLine (
        .Clock      (Clock),
        .rst        (rst),
        .lineStart  (lineStart),
        .lineEdge   (lineEdge),
        .lineBusy   (lineBusy),
        .lineDone   (lineDone),
        .pointValid (pointValid),
        .point      (point)
    );

    // screen clip and output register
    pixelClip uClip (
        .Clock      (Clock),
        .rst        (rst),
        .pointValid (pointValid),
        .point      (point),
        .drawColor  (drawColor),
        .pixelValid (pixelValid),
        .pixel      (pixel)
    );

endmodule

`default_nettype wire

//--- rtl/pixelClip.sv
`timescale 1ns/100ps
`default_nettype none

module pixelClip
    import polyPkg::*;
(
    input  wire logic   Clock,
    input  wire logic   rst,
    input  wire logic   pointValid,
    input  wire vertexT point,                  // signed drawing coordinates
    input  wire colorT  drawColor,
    output logic        pixelValid,             // one cycle after pointValid
    output pixelT       pixel
);

    logic onScreen;
    logic keep;

    // ========================================================================
    // bounds test against the visible area
    // ========================================================================
    assign onScreen = (point.x >= 0) && (point.x < ScreenWidth) &&
                      (point.y >= 0) && (point.y < ScreenHeight);
    assign keep     = pointValid && onScreen;   // off-screen points vanish

    always_ff @(posedge Clock) begin
        if (rst) begin
            pixelValid <= 1'b0;
        end else begin
            pixelValid <= keep;
        end
    end

    // low bits only, range already checked
    always_ff @(posedge Clock) begin
        if (keep) begin
            pixel.x     <= point.x[ScreenXWidth-1:0];
            pixel.y     <= point.y[ScreenYWidth-1:0];
            pixel.color <= drawColor;
        end
    end

    // every pixel leaving this stage lies inside the screen
    assert property (@(posedge Clock) disable iff (rst)
        pixelValid |-> (pixel.x < ScreenWidth) && (pixel.y < ScreenHeight));

endmodule

`default_nettype wire

//--- polygon/polygonSeq.sv
`timescale 1ns/100ps
`default_nettype none

module polygonSeq
    import polyPkg::*;
(
    input  wire logic  Clock,
    input  wire logic  rst,
    input  wire logic  start,
    input  wire quadT  quad,
    input  wire colorT color,
    input  wire logic  lineBusy,
    input  wire logic  lineDone,
    output logic       lineStart,               // one-cycle pulse per edge
    output lineT       lineEdge,                // endpoints for the stepper
    output colorT      drawColor,               // color of the whole frame
    output logic       busy,
    output logic       frameDone
);

    typedef enum logic [1:0] {
        Idle,
        Load,                                   // pick the next edge
        Draw,                                   // wait for the stepper
        Finish                                  // frame complete
    } seqStateT;

    seqStateT   state;
    logic [1:0] edgeCnt;                        // 0..3, edge being drawn
    logic       accept;
    quadT       quadReg;
    lineT       edgeSel;

    assign busy      = (state == Load) || (state == Draw);
    assign frameDone = (state == Finish);       // busy already low here
    assign accept    = start && !busy;          // Idle or Finish

    // ========================================================================
    // edge mux over the latched quad
    // ========================================================================
    always_comb begin
        case (edgeCnt)
            2'd0:    edgeSel = '{p0: quadReg.v0, p1: quadReg.v1};
            2'd1:    edgeSel = '{p0: quadReg.v1, p1: quadReg.v2};
            2'd2:    edgeSel = '{p0: quadReg.v2, p1: quadReg.v3};
            default: edgeSel = '{p0: quadReg.v3, p1: quadReg.v0};   // closing edge
        endcase
    end

    // ========================================================================
    // sequencer FSM
    // ========================================================================
    always_ff @(posedge Clock) begin
        if (rst) begin
            state     <= Idle;
            edgeCnt   <= '0;
            lineStart <= 1'b0;
        end else begin
            lineStart <= (state == Load);       // high in the first Draw cycle
            case (state)
                Load: state <= Draw;
                Draw: begin
                    if (lineDone) begin
                        edgeCnt <= edgeCnt + 2'd1;
                        // last edge done so the frame ends
                        state   <= (edgeCnt == 2'd3) ? Finish : Load;
                    end
                end
                default: begin                  // Idle and Finish
                    if (accept) begin
                        state   <= Load;
                        edgeCnt <= '0;
                    end else begin
                        state   <= Idle;
                    end
                end
            endcase
        end
    end

    // payload
    always_ff @(posedge Clock) begin
        if (accept) begin
            quadReg   <= quad;
            drawColor <= color;
        end
        if (state == Load) begin
            lineEdge <= edgeSel;                // stable before lineStart
        end
    end

    // ========================================================================
    // checks
    // ========================================================================
    // never hand a line to a busy stepper
    assert property (@(posedge Clock) disable iff (rst)
        !(lineStart && lineBusy));

    // completion pulses only arrive while we wait for them
    assert property (@(posedge Clock) disable iff (rst)
        lineDone |-> (state == Draw));

endmodule

`default_nettype wire

//--- lineDraw/lineDraw.sv
`timescale 1ns/100ps
`default_nettype none

module lineDraw
    import polyPkg::*;
(
    input  wire logic Clock,
    input  wire logic rst,
    input  wire logic lineStart,                // taken only while lineBusy is low
    input  wire lineT lineEdge,                 // endpoints of the line
    output logic      lineBusy,
    output logic      lineDone,                 // one cycle after the last point
    output logic      pointValid,
    output vertexT    point
);

    typedef enum logic [1:0] {
        Idle,
        Setup,                                  // deltas computed here
        Draw,                                   // one point per clock
        Done                                    // completion pulse
    } lineStateT;

    lineStateT state;
    logic      accept;

    // latched endpoints and walk state
    lineT   ends;
    vertexT cur;                                // point shown this cycle
    logic   incX;                               // 1 means x grows toward p1
    logic   incY;
    logic   atEnd;

    // bresenham terms with dy kept as the negated absolute delta
    logic signed [ErrWidth-1:0] diffX;
    logic signed [ErrWidth-1:0] diffY;
    logic signed [ErrWidth-1:0] absX;
    logic signed [ErrWidth-1:0] absY;
    logic signed [ErrWidth-1:0] dx;
    logic signed [ErrWidth-1:0] dy;
    logic signed [ErrWidth-1:0] err;
    logic signed [ErrWidth-1:0] err2;
    logic signed [ErrWidth-1:0] errNext;
    vertexT                     curNext;

    assign lineBusy   = (state == Setup) || (state == Draw);
    assign pointValid = (state == Draw);
    assign lineDone   = (state == Done);
    assign point      = cur;

    assign accept = lineStart && !lineBusy;     // Idle or Done
    assign atEnd  = (cur == ends.p1);           // last point reached

    // ========================================================================
    // setup arithmetic on the latched endpoints
    // ========================================================================
    assign diffX = ErrWidth'($signed(ends.p1.x)) - ErrWidth'($signed(ends.p0.x));
    assign diffY = ErrWidth'($signed(ends.p1.y)) - ErrWidth'($signed(ends.p0.y));
    assign absX  = diffX[ErrWidth-1] ? -diffX : diffX;
    assign absY  = diffY[ErrWidth-1] ? -diffY : diffY;

    // ========================================================================
    // one bresenham step from the current point
    // ========================================================================
    always_comb begin
        err2    = err <<< 1;
        errNext = err;
        curNext = cur;
        if (err2 >= dy) begin                   // x step
            errNext   = errNext + dy;
            curNext.x = incX ? cur.x + coordT'(1) : cur.x - coordT'(1);
        end
        if (err2 <= dx) begin                   // y step
            errNext   = errNext + dx;
            curNext.y = incY ? cur.y + coordT'(1) : cur.y - coordT'(1);
        end
    end

    // control
    always_ff @(posedge Clock) begin
        if (rst) begin
            state <= Idle;
        end else begin
            case (state)
                Setup: state <= Draw;
                Draw: begin
                    if (atEnd) begin
                        state <= Done;          // p1 was just shown
                    end
                end
                default: begin                  // Idle and Done
                    state <= accept ? Setup : Idle;
                end
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge Clock) begin
        if (accept) begin
            ends <= lineEdge;
        end
        if (state == Setup) begin
            cur  <= ends.p0;
            dx   <= absX;
            dy   <= -absY;
            err  <= absX - absY;                // dx + dy
            incX <= !diffX[ErrWidth-1];
            incY <= !diffY[ErrWidth-1];
        end else if ((state == Draw) && !atEnd) begin
            cur <= curNext;
            err <= errNext;
        end
    end

    // ========================================================================
    // checks
    // ========================================================================
    // true when two coordinates differ by at most one
    function automatic logic nearBy(input coordT a, input coordT b);
        return (a == b) || (a == b + coordT'(1)) || (b == a + coordT'(1));
    endfunction

    // the done pulse never overlaps a point
    assert property (@(posedge Clock) disable iff (rst)
        !(lineDone && pointValid));

    // consecutive points of one line are neighbours in one of eight directions
    assert property (@(posedge Clock) disable iff (rst)
        (pointValid && $past(pointValid)) |->
            nearBy(point.x, $past(point.x)) && nearBy(point.y, $past(point.y)) &&
            (point != $past(point)));

endmodule

`default_nettype wire

//--- common/polyPkg.sv
`default_nettype none

package polyPkg;

    // ========================================================================
    // screen geometry and word widths
    // ========================================================================
    localparam int ScreenWidth  = 640;          // visible columns
    localparam int ScreenHeight = 480;          // visible rows
    localparam int CoordWidth   = 12;           // signed drawing coordinates
    localparam int ScreenXWidth = 10;           // enough for 0..639
    localparam int ScreenYWidth = 9;            // enough for 0..479
    localparam int ColorWidth   = 3;            // one bit per channel

    // deltas and error term of the line stepper
    // two bits over a coordinate difference so that 2*err never overflows
    localparam int ErrWidth     = CoordWidth + 3;

    // ========================================================================
    // shared types
    // ========================================================================
    typedef logic signed [CoordWidth-1:0] coordT;
    typedef logic [ColorWidth-1:0]        colorT;

    typedef struct packed {
        coordT x;
        coordT y;
    } vertexT;                                  // 24 bits

    typedef struct packed {
        vertexT v0;
        vertexT v1;
        vertexT v2;
        vertexT v3;
    } quadT;                                    // 96 bits, edges run v0 to v3 and back

    typedef struct packed {
        vertexT p0;                             // first point drawn
        vertexT p1;                             // last point drawn, inclusive
    } lineT;

    typedef struct packed {
        logic [ScreenXWidth-1:0] x;
        logic [ScreenYWidth-1:0] y;
        colorT                   color;
    } pixelT;                                   // 22 bits

endpackage

`default_nettype wire
